//--- files.f
common/axi_mem_pkg.sv
logic/msg_buffer.sv
logic/msg_arbiter.sv
axi_sub/axi_sub_write.sv
axi_sub/axi_sub_read.sv
logic/axi_mem_bridge.sv
test/tb_mem_model.sv
test/tb_axi_mem_bridge.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_axi_mem_bridge \
  -f files.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log; echo "Build or simulation ended with an error" >> sim.log; }
cat sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0

//--- test/tb_axi_mem_bridge.sv
/*
 * Testbench for the AXI to memory message bridge. Directed tests
 * drive the AXI ports and check the answers of the memory model.
 */
`timescale 1ns/1ps

module tb_axi_mem_bridge
  import axi_mem_pkg::*;
();

  localparam int         timeout_cycles = 200;
  localparam logic [1:0] resp_okay      = 2'b00;
  localparam logic [1:0] resp_slverr    = 2'b10;
  localparam logic [7:0] src_id         = 8'h2c;
  localparam int         ch_aw = 0;
  localparam int         ch_w  = 1;
  localparam int         ch_ar = 2;
  localparam int         ch_b  = 3;
  localparam int         ch_r  = 4;

  logic         clk;
  logic         arst_n;
  logic [63:0]  awaddr;
  logic [3:0]   awid;
  logic [7:0]   awlen;
  logic [2:0]   awsize;
  logic         awvalid;
  logic         awready;
  logic [63:0]  wdata;
  logic [7:0]   wstrb;
  logic         wlast;
  logic         wvalid;
  logic         wready;
  logic [3:0]   bid;
  logic [1:0]   bresp;
  logic         bvalid;
  logic         bready;
  logic [63:0]  araddr;
  logic [3:0]   arid;
  logic [7:0]   arlen;
  logic [2:0]   arsize;
  logic         arvalid;
  logic         arready;
  logic [63:0]  rdata;
  logic [3:0]   rid;
  logic [1:0]   rresp;
  logic         rlast;
  logic         rvalid;
  logic         rready;
  mem_fwd_msg_t fwd_msg;
  logic         fwd_v;
  logic         fwd_ready;
  mem_rev_msg_t rev_msg;
  logic         rev_v;
  logic         rev_ready;
  integer       seed;

  axi_mem_bridge #(.id_width_p(4)) u_dut (
    .clk_i(clk), .arst_n_i(arst_n),
    .s_axi_awaddr_i(awaddr), .s_axi_awid_i(awid), .s_axi_awlen_i(awlen),
    .s_axi_awsize_i(awsize), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
    .s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wlast_i(wlast),
    .s_axi_wvalid_i(wvalid), .s_axi_wready_o(wready),
    .s_axi_bid_o(bid), .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid),
    .s_axi_bready_i(bready),
    .s_axi_araddr_i(araddr), .s_axi_arid_i(arid), .s_axi_arlen_i(arlen),
    .s_axi_arsize_i(arsize), .s_axi_arvalid_i(arvalid), .s_axi_arready_o(arready),
    .s_axi_rdata_o(rdata), .s_axi_rid_o(rid), .s_axi_rresp_o(rresp),
    .s_axi_rlast_o(rlast), .s_axi_rvalid_o(rvalid), .s_axi_rready_i(rready),
    .src_id_i(src_id),
    .mem_fwd_msg_o(fwd_msg), .mem_fwd_v_o(fwd_v), .mem_fwd_ready_i(fwd_ready),
    .mem_rev_msg_i(rev_msg), .mem_rev_v_i(rev_v), .mem_rev_ready_o(rev_ready)
  );

  tb_mem_model u_mem (
    .clk_i(clk), .arst_n_i(arst_n),
    .fwd_msg_i(fwd_msg), .fwd_v_i(fwd_v), .fwd_ready_o(fwd_ready),
    .rev_msg_o(rev_msg), .rev_v_o(rev_v), .rev_ready_i(rev_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ########################################
  // Reporting and waits
  // ########################################
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  function automatic logic chan_active(input int ch);
    case (ch)
      ch_aw:   return awready;
      ch_w:    return wready;
      ch_ar:   return arready;
      ch_b:    return bvalid;
      default: return rvalid;
    endcase
  endfunction

  // Samples on the falling edge, where outputs are settled.
  task automatic wait_chan(input int ch, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!chan_active(ch) && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!chan_active(ch)) begin
      abort_run($sformatf("Timed out waiting for %s", what));
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // ########################################
  // AXI driver tasks
  // ########################################
  task automatic send_aw(input logic [3:0] id, input logic [63:0] addr,
                         input logic [2:0] size, input logic [7:0] len);
    awid    = id;
    awaddr  = addr;
    awsize  = size;
    awlen   = len;
    awvalid = 1'b1;
    wait_chan(ch_aw, "AW ready");
    @(posedge clk);
    #2;
    awvalid = 1'b0;
  endtask

  task automatic send_w(input logic [63:0] data, input logic last);
    wdata  = data;
    wstrb  = 8'hff;
    wlast  = last;
    wvalid = 1'b1;
    wait_chan(ch_w, "W ready");
    @(posedge clk);
    #2;
    wvalid = 1'b0;
  endtask

  task automatic send_ar(input logic [3:0] id, input logic [63:0] addr, input logic [7:0] len);
    arid    = id;
    araddr  = addr;
    arsize  = 3'd3;
    arlen   = len;
    arvalid = 1'b1;
    wait_chan(ch_ar, "AR ready");
    @(posedge clk);
    #2;
    arvalid = 1'b0;
  endtask

  task automatic collect_b(input int stall, input logic [3:0] exp_id, input logic [1:0] exp_resp);
    idle_cycles(stall); // Manager not ready yet.
    bready = 1'b1;
    wait_chan(ch_b, "B valid");
    check_eq("bid", 64'(bid), 64'(exp_id));
    check_eq("bresp", 64'(bresp), 64'(exp_resp));
    @(posedge clk);
    #2;
    bready = 1'b0;
  endtask

  task automatic collect_r(input int stall, input logic [3:0] exp_id,
                           input logic [1:0] exp_resp, output logic [63:0] data);
    idle_cycles(stall);
    rready = 1'b1;
    wait_chan(ch_r, "R valid");
    check_eq("rid", 64'(rid), 64'(exp_id));
    check_eq("rresp", 64'(rresp), 64'(exp_resp));
    check_eq("rlast", 64'(rlast), 64'd1);
    data = rdata;
    @(posedge clk);
    #2;
    rready = 1'b0;
  endtask

  task automatic write_beats(input logic [3:0] id, input logic [63:0] addr,
                             input logic [2:0] size, input logic [7:0] len,
                             input logic [63:0] data, input int aw_delay, input int w_delay);
    fork
      begin
        idle_cycles(aw_delay);
        send_aw(id, addr, size, len);
      end
      begin
        idle_cycles(w_delay);
        send_w(data, len == 8'd0);
      end
    join
  endtask

  task automatic write_txn(input logic [3:0] id, input logic [63:0] addr,
                           input logic [2:0] size, input logic [63:0] data,
                           input int aw_delay, input int w_delay, input int b_stall);
    write_beats(id, addr, size, 8'd0, data, aw_delay, w_delay);
    collect_b(b_stall, id, resp_okay);
  endtask

  task automatic read_check(input logic [3:0] id, input logic [63:0] addr,
                            input logic [63:0] exp, input int r_stall);
    logic [63:0] got;
    send_ar(id, addr, 8'd0);
    collect_r(r_stall, id, resp_okay, got);
    check_eq("rdata", got, exp);
  endtask

  // ########################################
  // Directed tests
  // ########################################
  task automatic test_reset_state;
    @(negedge clk);
    check_eq("awready", 64'(awready), 64'd1);
    check_eq("wready", 64'(wready), 64'd1);
    check_eq("arready", 64'(arready), 64'd1);
    check_eq("bvalid", 64'(bvalid), 64'd0);
    check_eq("rvalid", 64'(rvalid), 64'd0);
    check_eq("mem_fwd_v", 64'(fwd_v), 64'd0);
    @(posedge clk);
    #2;
  endtask

  task automatic test_write_read;
    write_txn(4'h5, 64'h40, 3'd3, 64'h0123_4567_89ab_cdef, 0, 0, 0);
    read_check(4'ha, 64'h40, 64'h0123_4567_89ab_cdef, 0);
  endtask

  task automatic test_byte_write;
    logic [63:0] exp;
    exp = 64'hfeed_face_1357_9bdf;
    write_txn(4'h1, 64'h100, 3'd3, exp, 0, 0, 0);
    write_txn(4'h2, 64'h103, 3'd0, 64'h8877_6655_4433_223c, 0, 0, 0); // Low byte only.
    exp[31:24] = 8'h3c;
    read_check(4'h3, 64'h100, exp, 0);
  endtask

  task automatic test_write_order;
    write_txn(4'h6, 64'h180, 3'd3, 64'h1111_2222_3333_4444, 4, 0, 0); // W first.
    write_txn(4'h7, 64'h188, 3'd3, 64'h5555_6666_7777_8888, 0, 6, 0); // W late.
    read_check(4'h8, 64'h180, 64'h1111_2222_3333_4444, 0);
    read_check(4'h9, 64'h188, 64'h5555_6666_7777_8888, 0);
  endtask

  task automatic test_concurrent;
    logic [63:0] got;
    int          wr_before;
    int          rd_before;
    write_txn(4'h1, 64'h300, 3'd3, 64'h5555_aaaa_0f0f_f0f0, 0, 0, 0);
    wr_before = u_mem.wr_count;
    rd_before = u_mem.rd_count;
    fork
      write_beats(4'h2, 64'h200, 3'd3, 8'd0, 64'h1122_3344_5566_7788, 0, 0);
      send_ar(4'h3, 64'h300, 8'd0);
    join
    fork
      collect_b(0, 4'h2, resp_okay);
      collect_r(0, 4'h3, resp_okay, got);
    join
    check_eq("rdata", got, 64'h5555_aaaa_0f0f_f0f0);
    check_eq("write msg count", 64'(u_mem.wr_count - wr_before), 64'd1);
    check_eq("read msg count", 64'(u_mem.rd_count - rd_before), 64'd1);
    check_eq("write src_id", 64'(u_mem.wr_src), 64'(src_id));
    check_eq("read src_id", 64'(u_mem.rd_src), 64'(src_id));
    read_check(4'h4, 64'h200, 64'h1122_3344_5566_7788, 0);
  endtask

  task automatic test_burst_error;
    logic [63:0] got;
    int          wr_before;
    int          rd_before;
    wr_before = u_mem.wr_count;
    rd_before = u_mem.rd_count;
    write_beats(4'h9, 64'h400, 3'd3, 8'd3, 64'hdead_beef_dead_beef, 0, 0);
    collect_b(0, 4'h9, resp_slverr);
    send_ar(4'hb, 64'h400, 8'd1);
    collect_r(0, 4'hb, resp_slverr, got);
    idle_cycles(8);
    check_eq("write msg count", 64'(u_mem.wr_count - wr_before), 64'd0);
    check_eq("read msg count", 64'(u_mem.rd_count - rd_before), 64'd0);
  endtask

  task automatic test_stress;
    logic [63:0] data;
    logic [63:0] addr;
    for (int i = 0; i < 10; i++) begin
      data = {$random(seed), $random(seed)};
      addr = 64'h500 + 64'(i * 8);
      write_txn(4'(i), addr, 3'd3, data, 0, 0, $random(seed) & 7);
      read_check(4'(i + 5), addr, data, $random(seed) & 7);
    end
  endtask

  initial begin
    seed    = 32'hbcd3_d2be;
    arst_n  = 1'b0;
    awaddr  = '0;
    awid    = '0;
    awlen   = '0;
    awsize  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arid    = '0;
    arlen   = '0;
    arsize  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;
    test_reset_state();
    test_write_read();
    test_byte_write();
    test_write_order();
    test_concurrent();
    test_burst_error();
    test_stress();
    $display("All tests passed");
    $finish;
  end

endmodule

//--- test/tb_mem_model.sv
/*
 * Memory model for the bridge testbench. Answers each uncached
 * request after a random delay and stalls its request ready at random.
 */
`timescale 1ns/1ps

module tb_mem_model
  import axi_mem_pkg::*;
(
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  mem_fwd_msg_t fwd_msg_i,
  input  logic         fwd_v_i,
  output logic         fwd_ready_o,
  output mem_rev_msg_t rev_msg_o,
  output logic         rev_v_o,
  input  logic         rev_ready_i
);

  logic [63:0]             mem [0:255]; // Byte address bits 10:0.
  logic                    rdy_q;
  logic                    busy_q;      // One request in service.
  logic [1:0]              delay_q;
  logic [10:0]             baddr;
  integer                  seed;
  int                      rnd;
  int                      wr_count;
  int                      rd_count;
  logic [src_id_width-1:0] wr_src;
  logic [src_id_width-1:0] rd_src;

  assign fwd_ready_o = rdy_q & ~busy_q;

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      seed = 32'hbcd3_d2be;
      for (int i = 0; i < 256; i++) begin
        mem[i] = {24'hc0de00, 8'(i), 24'h5a5a5a, ~8'(i)}; // Fill tracks the word address.
      end
      rdy_q     <= 1'b0;
      busy_q    <= 1'b0;
      delay_q   <= 2'd0;
      rev_v_o   <= 1'b0;
      rev_msg_o <= '0;
      wr_count  <= 0;
      rd_count  <= 0;
      wr_src    <= '0;
      rd_src    <= '0;
    end else begin
      rnd = $random(seed);
      rdy_q <= rnd[0] | rnd[1]; // Ready about three cycles in four.
      if (fwd_v_i && fwd_ready_o) begin
        busy_q             <= 1'b1;
        delay_q            <= rnd[3:2];
        rev_msg_o.msg_type <= fwd_msg_i.msg_type;
        rev_msg_o.size     <= fwd_msg_i.size;
        rev_msg_o.addr     <= fwd_msg_i.addr;
        if (fwd_msg_i.msg_type == msg_uc_wr) begin
          // Low 2^size bytes of the data land at the address.
          for (int k = 0; k < 8; k++) begin
            if (k < (1 << fwd_msg_i.size)) begin
              baddr = fwd_msg_i.addr[10:0] + 11'(k);
              mem[baddr[10:3]][baddr[2:0]*8 +: 8] = fwd_msg_i.data[k*8 +: 8];
            end
          end
          rev_msg_o.data <= '0;
          wr_count       <= wr_count + 1;
          wr_src         <= fwd_msg_i.src_id;
        end else begin
          rev_msg_o.data <= mem[fwd_msg_i.addr[10:3]]; // Aligned word.
          rd_count       <= rd_count + 1;
          rd_src         <= fwd_msg_i.src_id;
        end
      end
      if (busy_q && !rev_v_o) begin
        if (delay_q == 2'd0) begin
          rev_v_o <= 1'b1;
        end else begin
          delay_q <= delay_q - 2'd1;
        end
      end
      if (rev_v_o && rev_ready_i) begin
        rev_v_o <= 1'b0;
        busy_q  <= 1'b0;
      end
    end
  end

endmodule

//--- logic/axi_mem_bridge.sv
/*
 * AXI4 subordinate to uncached memory message bridge.
 * One read and one write in flight, sharing one request stream.
 */
`timescale 1ns/1ps

module axi_mem_bridge
  import axi_mem_pkg::*;
#(
  parameter int id_width_p = 4
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic [63:0]               s_axi_awaddr_i,
  input  logic [id_width_p-1:0]     s_axi_awid_i,
  input  logic [7:0]                s_axi_awlen_i,
  input  logic [2:0]                s_axi_awsize_i,
  input  logic                      s_axi_awvalid_i,
  output logic                      s_axi_awready_o,
  input  logic [63:0]               s_axi_wdata_i,
  input  logic [7:0]                s_axi_wstrb_i,
  input  logic                      s_axi_wlast_i,
  input  logic                      s_axi_wvalid_i,
  output logic                      s_axi_wready_o,
  output logic [id_width_p-1:0]     s_axi_bid_o,
  output logic [1:0]                s_axi_bresp_o,
  output logic                      s_axi_bvalid_o,
  input  logic                      s_axi_bready_i,
  input  logic [63:0]               s_axi_araddr_i,
  input  logic [id_width_p-1:0]     s_axi_arid_i,
  input  logic [7:0]                s_axi_arlen_i,
  input  logic [2:0]                s_axi_arsize_i,
  input  logic                      s_axi_arvalid_i,
  output logic                      s_axi_arready_o,
  output logic [mem_data_width-1:0] s_axi_rdata_o,
  output logic [id_width_p-1:0]     s_axi_rid_o,
  output logic [1:0]                s_axi_rresp_o,
  output logic                      s_axi_rlast_o,
  output logic                      s_axi_rvalid_o,
  input  logic                      s_axi_rready_i,
  input  logic [src_id_width-1:0]   src_id_i,
  output mem_fwd_msg_t              mem_fwd_msg_o,
  output logic                      mem_fwd_v_o,
  input  logic                      mem_fwd_ready_i,
  input  mem_rev_msg_t              mem_rev_msg_i,
  input  logic                      mem_rev_v_i,
  output logic                      mem_rev_ready_o
);

  mem_fwd_msg_t              wr_req_msg;
  mem_fwd_msg_t              rd_req_msg;
  mem_fwd_msg_t              arb_fwd_msg;
  mem_rev_msg_t              rev_buf_msg;
  logic                      wr_req_v;
  logic                      wr_req_ready;
  logic                      rd_req_v;
  logic                      rd_req_ready;
  logic                      arb_fwd_v;
  logic                      arb_fwd_ready;
  logic                      rev_buf_v;
  logic                      rev_buf_ready;
  logic                      wr_rsp_v;
  logic                      wr_rsp_ready;
  logic                      rd_rsp_v;
  logic                      rd_rsp_ready;
  logic [mem_data_width-1:0] rd_rsp_data;

  // ########################################
  // AXI front ends
  // ########################################
  axi_sub_write #(.id_width_p(id_width_p)) u_write (
    .clk_i, .arst_n_i,
    .s_axi_awaddr_i, .s_axi_awid_i, .s_axi_awlen_i, .s_axi_awsize_i,
    .s_axi_awvalid_i, .s_axi_awready_o,
    .s_axi_wdata_i, .s_axi_wstrb_i, .s_axi_wlast_i, .s_axi_wvalid_i, .s_axi_wready_o,
    .s_axi_bid_o, .s_axi_bresp_o, .s_axi_bvalid_o, .s_axi_bready_i,
    .src_id_i,
    .req_msg_o(wr_req_msg), .req_v_o(wr_req_v), .req_ready_i(wr_req_ready),
    .rsp_v_i(wr_rsp_v), .rsp_ready_o(wr_rsp_ready)
  );

  axi_sub_read #(.id_width_p(id_width_p)) u_read (
    .clk_i, .arst_n_i,
    .s_axi_araddr_i, .s_axi_arid_i, .s_axi_arlen_i, .s_axi_arsize_i,
    .s_axi_arvalid_i, .s_axi_arready_o,
    .s_axi_rdata_o, .s_axi_rid_o, .s_axi_rresp_o, .s_axi_rlast_o,
    .s_axi_rvalid_o, .s_axi_rready_i,
    .src_id_i,
    .req_msg_o(rd_req_msg), .req_v_o(rd_req_v), .req_ready_i(rd_req_ready),
    .rsp_data_i(rd_rsp_data), .rsp_v_i(rd_rsp_v), .rsp_ready_o(rd_rsp_ready)
  );

  // ########################################
  // Message streams
  // ########################################
  msg_arbiter u_arb (
    .clk_i, .arst_n_i,
    .wr_msg_i(wr_req_msg), .wr_v_i(wr_req_v), .wr_ready_o(wr_req_ready),
    .rd_msg_i(rd_req_msg), .rd_v_i(rd_req_v), .rd_ready_o(rd_req_ready),
    .fwd_msg_o(arb_fwd_msg), .fwd_v_o(arb_fwd_v), .fwd_ready_i(arb_fwd_ready),
    .rev_msg_i(rev_buf_msg), .rev_v_i(rev_buf_v), .rev_ready_o(rev_buf_ready),
    .wr_rsp_v_o(wr_rsp_v), .rd_rsp_v_o(rd_rsp_v), .rd_rsp_data_o(rd_rsp_data),
    .wr_rsp_ready_i(wr_rsp_ready), .rd_rsp_ready_i(rd_rsp_ready)
  );

  msg_buffer #(.msg_t(mem_fwd_msg_t)) u_fwd_buf (
    .clk_i, .arst_n_i,
    .msg_i(arb_fwd_msg), .v_i(arb_fwd_v), .ready_o(arb_fwd_ready),
    .msg_o(mem_fwd_msg_o), .v_o(mem_fwd_v_o), .ready_i(mem_fwd_ready_i)
  );

  msg_buffer #(.msg_t(mem_rev_msg_t)) u_rev_buf (
    .clk_i, .arst_n_i,
    .msg_i(mem_rev_msg_i), .v_i(mem_rev_v_i), .ready_o(mem_rev_ready_o),
    .msg_o(rev_buf_msg), .v_o(rev_buf_v), .ready_i(rev_buf_ready)
  );

endmodule

//--- axi_sub/axi_sub_read.sv
/*
 * AXI read subordinate. Takes one AR beat, sends an uncached read
 * request and returns the data as a single R beat.
 */
`timescale 1ns/1ps

module axi_sub_read
  import axi_mem_pkg::*;
#(
  parameter int id_width_p = 4
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic [63:0]               s_axi_araddr_i,
  input  logic [id_width_p-1:0]     s_axi_arid_i,
  input  logic [7:0]                s_axi_arlen_i,
  input  logic [2:0]                s_axi_arsize_i,
  input  logic                      s_axi_arvalid_i,
  output logic                      s_axi_arready_o,
  output logic [mem_data_width-1:0] s_axi_rdata_o,
  output logic [id_width_p-1:0]     s_axi_rid_o,
  output logic [1:0]                s_axi_rresp_o,
  output logic                      s_axi_rlast_o,
  output logic                      s_axi_rvalid_o,
  input  logic                      s_axi_rready_i,
  input  logic [src_id_width-1:0]   src_id_i,
  output mem_fwd_msg_t              req_msg_o,
  output logic                      req_v_o,
  input  logic                      req_ready_i,
  input  logic [mem_data_width-1:0] rsp_data_i,
  input  logic                      rsp_v_i,
  output logic                      rsp_ready_o
);

  typedef enum logic [1:0] {st_idle, st_request, st_wait_rsp, st_respond} state_e;

  state_e                    state_q;
  logic                      err_q;
  logic [id_width_p-1:0]     id_q;
  logic [mem_addr_width-1:0] addr_q;
  logic [2:0]                size_q;
  logic [mem_data_width-1:0] data_q;
  logic                      ar_hs;

  assign s_axi_arready_o = (state_q == st_idle);
  assign ar_hs = s_axi_arvalid_i & s_axi_arready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= st_idle;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (ar_hs) begin
            err_q   <= (s_axi_arlen_i != 8'd0);
            state_q <= (s_axi_arlen_i != 8'd0) ? st_respond : st_request;
          end
        end
        st_request: begin
          if (req_ready_i) state_q <= st_wait_rsp;
        end
        st_wait_rsp: begin
          if (rsp_v_i) state_q <= st_respond;
        end
        st_respond: begin
          if (s_axi_rready_i) state_q <= st_idle;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      id_q   <= s_axi_arid_i;
      addr_q <= s_axi_araddr_i[mem_addr_width-1:0];
      size_q <= s_axi_arsize_i;
    end
    if (rsp_v_i && rsp_ready_o) begin
      data_q <= rsp_data_i; // Held for R.
    end
  end

  always_comb begin
    req_msg_o          = '0; // No write data on reads.
    req_msg_o.msg_type = msg_uc_rd;
    req_msg_o.size     = msg_size_e'(size_q);
    req_msg_o.addr     = addr_q;
    req_msg_o.src_id   = src_id_i;
  end

  assign req_v_o        = (state_q == st_request);
  assign rsp_ready_o    = (state_q == st_wait_rsp);
  assign s_axi_rvalid_o = (state_q == st_respond);
  assign s_axi_rdata_o  = data_q;
  assign s_axi_rid_o    = id_q;
  assign s_axi_rresp_o  = err_q ? axi_resp_slverr : axi_resp_okay;
  assign s_axi_rlast_o  = 1'b1; // Single beat only.

endmodule

//--- axi_sub/axi_sub_write.sv
/*
 * AXI write subordinate. Collects one AW and one W beat in either
 * order, sends an uncached write request and answers on B.
 */
`timescale 1ns/1ps

module axi_sub_write
  import axi_mem_pkg::*;
#(
  parameter int id_width_p = 4
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic [63:0]               s_axi_awaddr_i,
  input  logic [id_width_p-1:0]     s_axi_awid_i,
  input  logic [7:0]                s_axi_awlen_i,
  input  logic [2:0]                s_axi_awsize_i,
  input  logic                      s_axi_awvalid_i,
  output logic                      s_axi_awready_o,
  input  logic [63:0]               s_axi_wdata_i,
  input  logic [7:0]                s_axi_wstrb_i,
  input  logic                      s_axi_wlast_i,
  input  logic                      s_axi_wvalid_i,
  output logic                      s_axi_wready_o,
  output logic [id_width_p-1:0]     s_axi_bid_o,
  output logic [1:0]                s_axi_bresp_o,
  output logic                      s_axi_bvalid_o,
  input  logic                      s_axi_bready_i,
  input  logic [src_id_width-1:0]   src_id_i,
  output mem_fwd_msg_t              req_msg_o,
  output logic                      req_v_o,
  input  logic                      req_ready_i,
  input  logic                      rsp_v_i,
  output logic                      rsp_ready_o
);

  typedef enum logic [2:0] {st_idle, st_collect, st_request, st_wait_rsp, st_respond} state_e;

  state_e                    state_q;
  logic                      aw_got_q;
  logic                      w_got_q;
  logic                      err_q;
  logic [id_width_p-1:0]     id_q;
  logic [mem_addr_width-1:0] addr_q;
  logic [2:0]                size_q;
  logic [mem_data_width-1:0] data_q;
  logic                      aw_hs;
  logic                      w_hs;
  logic                      burst_err;

  assign s_axi_awready_o = (state_q == st_idle || state_q == st_collect) && !aw_got_q;
  assign s_axi_wready_o  = (state_q == st_idle || state_q == st_collect) && !w_got_q;
  assign aw_hs = s_axi_awvalid_i & s_axi_awready_o;
  assign w_hs  = s_axi_wvalid_i & s_axi_wready_o;
  // Anything but a single last beat is refused.
  assign burst_err = err_q | (aw_hs & (s_axi_awlen_i != 8'd0)) | (w_hs & ~s_axi_wlast_i);

  // ########################################
  // Control FSM
  // ########################################
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= st_idle;
      aw_got_q <= 1'b0;
      w_got_q  <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      case (state_q)
        st_idle, st_collect: begin
          if (aw_hs || w_hs) begin
            aw_got_q <= aw_got_q | aw_hs;
            w_got_q  <= w_got_q | w_hs;
            err_q    <= burst_err;
          end
          if ((aw_got_q || aw_hs) && (w_got_q || w_hs)) begin
            state_q <= burst_err ? st_respond : st_request; // Errors skip memory.
          end else if (aw_hs || w_hs) begin
            state_q <= st_collect;
          end
        end
        st_request: begin
          if (req_ready_i) state_q <= st_wait_rsp;
        end
        st_wait_rsp: begin
          if (rsp_v_i) state_q <= st_respond;
        end
        st_respond: begin
          if (s_axi_bready_i) begin
            state_q  <= st_idle;
            aw_got_q <= 1'b0;
            w_got_q  <= 1'b0;
            err_q    <= 1'b0;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Beat holding registers.
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      id_q   <= s_axi_awid_i;
      addr_q <= s_axi_awaddr_i[mem_addr_width-1:0]; // Upper bits dropped.
      size_q <= s_axi_awsize_i;
    end
    if (w_hs) begin
      data_q <= s_axi_wdata_i; // Strobes not forwarded.
    end
  end

  always_comb begin
    req_msg_o          = '0;
    req_msg_o.msg_type = msg_uc_wr;
    req_msg_o.size     = msg_size_e'(size_q);
    req_msg_o.addr     = addr_q;
    req_msg_o.src_id   = src_id_i;
    req_msg_o.data     = data_q;
  end

  assign req_v_o        = (state_q == st_request);
  assign rsp_ready_o    = (state_q == st_wait_rsp);
  assign s_axi_bvalid_o = (state_q == st_respond);
  assign s_axi_bid_o    = id_q;
  assign s_axi_bresp_o  = err_q ? axi_resp_slverr : axi_resp_okay;

  // B holds until the manager takes it.
  a_bvalid_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o && $stable(s_axi_bid_o)
  );

endmodule

//--- logic/msg_arbiter.sv
/*
 * Round-robin arbiter for the write and read request streams, and
 * router that returns response messages to the unit by type.
 */
`timescale 1ns/1ps

module msg_arbiter
  import axi_mem_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  mem_fwd_msg_t              wr_msg_i,
  input  logic                      wr_v_i,
  output logic                      wr_ready_o,
  input  mem_fwd_msg_t              rd_msg_i,
  input  logic                      rd_v_i,
  output logic                      rd_ready_o,
  output mem_fwd_msg_t              fwd_msg_o,
  output logic                      fwd_v_o,
  input  logic                      fwd_ready_i,
  input  mem_rev_msg_t              rev_msg_i,
  input  logic                      rev_v_i,
  output logic                      rev_ready_o,
  output logic                      wr_rsp_v_o,
  output logic                      rd_rsp_v_o,
  output logic [mem_data_width-1:0] rd_rsp_data_o,
  input  logic                      wr_rsp_ready_i,
  input  logic                      rd_rsp_ready_i
);

  logic last_wr_q;  // Write won the last transfer.
  logic hold_q;     // Grant is locked by a stall.
  logic hold_wr_q;
  logic wr_gnt;
  logic rd_gnt;
  logic rev_is_wr;

  // ########################################
  // Forward arbitration
  // ########################################
  always_comb begin
    if (hold_q) begin
      wr_gnt = hold_wr_q;
      rd_gnt = ~hold_wr_q;
    end else if (wr_v_i && rd_v_i) begin
      wr_gnt = ~last_wr_q; // Loser of last round goes first.
      rd_gnt = last_wr_q;
    end else begin
      wr_gnt = wr_v_i;
      rd_gnt = rd_v_i;
    end
  end

  assign fwd_v_o    = (wr_gnt & wr_v_i) | (rd_gnt & rd_v_i);
  assign fwd_msg_o  = wr_gnt ? wr_msg_i : rd_msg_i;
  assign wr_ready_o = wr_gnt & fwd_ready_i;
  assign rd_ready_o = rd_gnt & fwd_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_wr_q <= 1'b0;
      hold_q    <= 1'b0;
      hold_wr_q <= 1'b0;
    end else begin
      hold_q    <= fwd_v_o & ~fwd_ready_i;
      hold_wr_q <= wr_gnt;
      if (fwd_v_o && fwd_ready_i) begin
        last_wr_q <= wr_gnt;
      end
    end
  end

  // ########################################
  // Response routing
  // ########################################
  assign rev_is_wr     = (rev_msg_i.msg_type == msg_uc_wr);
  assign wr_rsp_v_o    = rev_v_i & rev_is_wr;
  assign rd_rsp_v_o    = rev_v_i & ~rev_is_wr;
  assign rd_rsp_data_o = rev_msg_i.data;
  assign rev_ready_o   = rev_is_wr ? wr_rsp_ready_i : rd_rsp_ready_i;

  a_grant_excl: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !(wr_gnt && rd_gnt)
  );

endmodule

//--- logic/msg_buffer.sv
/*
 * One-entry registered stream buffer for any message type.
 * Sustains one item per cycle when the consumer keeps up.
 */
`timescale 1ns/1ps

module msg_buffer #(
  parameter type msg_t = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  msg_t msg_i,
  input  logic v_i,
  output logic ready_o,
  output msg_t msg_o,
  output logic v_o,
  input  logic ready_i
);

  logic full_q;
  msg_t msg_q;

  // Accepts while empty or while the slot drains.
  assign ready_o = ~full_q | ready_i;
  assign v_o     = full_q;
  assign msg_o   = msg_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (ready_o) begin
      full_q <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && ready_o) begin
      msg_q <= msg_i; // Payload slot.
    end
  end

  a_msg_stable: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    v_o && !ready_i |=> v_o && $stable(msg_o)
  );

endmodule

//--- common/axi_mem_pkg.sv
/*
 * Shared definitions for the AXI to memory message bridge.
 * Message types, sizes, payload structs and AXI response codes.
 */

package axi_mem_pkg;

  localparam int mem_addr_width = 40;
  localparam int mem_data_width = 64;
  localparam int src_id_width   = 8;

  typedef enum logic {
    msg_uc_rd = 1'b0,
    msg_uc_wr = 1'b1
  } msg_type_e;

  // Log2 of the byte count.
  typedef enum logic [2:0] {
    msg_size_1 = 3'd0,
    msg_size_2 = 3'd1,
    msg_size_4 = 3'd2,
    msg_size_8 = 3'd3
  } msg_size_e;

  typedef struct packed {
    msg_type_e                 msg_type;
    msg_size_e                 size;
    logic [mem_addr_width-1:0] addr;
    logic [src_id_width-1:0]   src_id;
    logic [mem_data_width-1:0] data;
  } mem_fwd_msg_t; // 116 bits.

  typedef struct packed {
    msg_type_e                 msg_type;
    msg_size_e                 size;
    logic [mem_addr_width-1:0] addr;
    logic [mem_data_width-1:0] data;
  } mem_rev_msg_t; // 108 bits.

  localparam logic [1:0] axi_resp_okay   = 2'b00;
  localparam logic [1:0] axi_resp_slverr = 2'b10;

endpackage
